// ==== all.f ====
+incdir+design
design/jtag2ahb_pkg.sv
design/jtag_tap.sv
design/jtag_cdc_channel.sv
design/jtag_cmd_unit.sv
design/ahb_single_master.sv
design/jtag2ahb_bridge.sv
testbench/tb_clock_gen.sv
testbench/tb_ahb_mem.sv
testbench/jtag2ahb_props.sv
testbench/tb_jtag2ahb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_jtag2ahb
FILELIST  ?= all.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== testbench/tb_jtag2ahb.sv ====
// ****************************************
// Testbench for the JTAG to AHB bridge
// JTAG bit-bang tasks, reference memory,
// checks, watchdog and final verdict
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module tb_jtag2ahb;

	import jtag2ahb_pkg::*;

	localparam int NUM_WRITES = 20;
	localparam int NUM_READS = 9;
	localparam int SLOW_WAITS = 200;
	localparam int NUM_OPS = NUM_WRITES + NUM_READS + 16;
	localparam int CYCLES_PER_OP = 600;
	localparam int TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP;

	logic        clk;
	logic        rst_n = 1'b0;
	logic        tck = 1'b0;
	logic        tms = 1'b1;
	logic        tdi = 1'b0;
	logic        slow = 1'b0;
	wire         tdo;
	wire         tdo_en;
	wire  [31:0] haddr;
	wire  [2:0]  hburst;
	wire         hmastlock;
	wire  [3:0]  hprot;
	wire  [2:0]  hsize;
	wire  [1:0]  htrans;
	wire  [31:0] hwdata;
	wire         hwrite;
	wire  [31:0] hrdata;
	wire         hready;
	wire         hresp;

	logic [31:0] ref_mem [0:63];
	int          seed = 9;
	int          checks = 0;
	int          errors = 0;

	tb_clock_gen #(.PERIOD(8)) u_clk (.clk(clk));

	jtag2ahb_bridge DUT (
		.clk(clk), .rst_n(rst_n), .tck(tck), .tms(tms), .tdi(tdi),
		.tdo(tdo), .tdo_en(tdo_en), .haddr(haddr), .hburst(hburst),
		.hmastlock(hmastlock), .hprot(hprot), .hsize(hsize), .htrans(htrans),
		.hwdata(hwdata), .hwrite(hwrite), .hrdata(hrdata), .hready(hready),
		.hresp(hresp)
	);

	tb_ahb_mem #(.SLOW_WAITS(SLOW_WAITS)) u_mem (
		.clk(clk), .rst_n(rst_n), .slow(slow), .htrans(htrans), .haddr(haddr),
		.hwrite(hwrite), .hwdata(hwdata), .hrdata(hrdata), .hready(hready),
		.hresp(hresp)
	);

	function automatic logic [31:0] fill_word(input int idx);
		return 32'h5A5A_0000 ^ ((32'(idx) << 2) * 32'h0001_0001);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Error: %s expected %h actual %h", name, exp, act);
		end
	endtask

	// ****************************************
	// JTAG bit-bang
	// ****************************************

	// One tck period, two clk cycles, tdo taken just before the rise
	task automatic tck_cycle(input logic tms_v, input logic tdi_v, output logic tdo_v);
		@(posedge clk);
		tck <= 1'b0;
		tms <= tms_v;
		tdi <= tdi_v;
		@(posedge clk);
		tdo_v = tdo;
		tck <= 1'b1;
	endtask

	task automatic shift_ir(input logic [7:0] code);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < 8; i++) begin
			tck_cycle(i == 7, code[i], b);
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	task automatic shift_dr(input logic [31:0] din, output logic [31:0] dout);
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		for (int i = 0; i < 32; i++) begin
			tck_cycle(i == 31, din[i], b);
			dout[i] = b;
		end
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	// Capture, Exit1, Update with no shift: issues the command fast
	task automatic send_empty_dr();
		logic b;
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b1, 1'b0, b);
		tck_cycle(1'b0, 1'b0, b);
	endtask

	// Scans STATUS until busy clears, then once more for settled flags
	task automatic poll_idle(output logic [31:0] status);
		logic [31:0] st;
		shift_ir(IR_STATUS);
		shift_dr(32'd0, st);
		while (st[`STAT_BUSY]) begin
			shift_dr(32'd0, st);
		end
		shift_dr(32'd0, status);
	endtask

	task automatic send_addr(input logic [31:0] addr, output logic [31:0] status);
		logic [31:0] got;
		shift_ir(IR_ADDR);
		shift_dr(addr, got);
		poll_idle(status);
	endtask

	task automatic compare_memory(input string name);
		for (int i = 0; i < 64; i++) begin
			check_value(name, ref_mem[i], u_mem.mem[i]);
		end
	endtask

	// ****************************************
	// Watchdog
	// ****************************************
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

	// ****************************************
	// Test sequence
	// ****************************************
	initial begin
		logic [31:0] got;
		logic [31:0] pat;
		logic [31:0] st;
		logic        b;
		int          base;
		logic        exp_ovr;

		for (int i = 0; i < 64; i++) begin
			ref_mem[i] = fill_word(i);
		end

		// Reset with one tck rise and fall inside it
		@(posedge clk);
		tck <= 1'b1;
		@(posedge clk);
		tck <= 1'b0;
		rst_n <= 1'b1;
		for (int i = 0; i < 5; i++) begin
			tck_cycle(1'b1, 1'b0, b);
		end
		tck_cycle(1'b0, 1'b0, b);

		// IDCODE and bypass
		shift_dr(32'd0, got);
		check_value("idcode", `JTAG_IDCODE, got);
		shift_ir(IR_BYPASS);
		pat = $random(seed);
		shift_dr(pat, got);
		check_value("bypass", {pat[30:0], 1'b0}, got);
		shift_ir(8'h5A);
		pat = $random(seed);
		shift_dr(pat, got);
		check_value("unknown code bypass", {pat[30:0], 1'b0}, got);

		// Consecutive writes
		pat = $random(seed);
		base = int'(pat[5:0]) % (64 - NUM_WRITES);
		send_addr(32'(base) << 2, st);
		for (int i = 0; i < NUM_WRITES; i++) begin
			pat = $random(seed);
			shift_ir(IR_WDATA);
			shift_dr(pat, got);
			ref_mem[base + i] = pat;
			poll_idle(st);
		end
		compare_memory("write memory");

		// Reads return the previous read's word
		pat = $random(seed);
		base = int'(pat[5:0]) % (64 - NUM_READS);
		send_addr(32'(base) << 2, st);
		for (int i = 0; i <= NUM_READS; i++) begin
			shift_ir(IR_RDATA);
			shift_dr(32'd0, got);
			if (i > 0) begin
				check_value("read data", ref_mem[base + i - 1], got);
			end
			poll_idle(st);
		end

		// Bus error and its clearing
		send_addr(32'h180, st);
		shift_ir(IR_WDATA);
		pat = $random(seed);
		shift_dr(pat, got);
		poll_idle(st);
		check_value("error flag set", 32'd1, 32'(st[`STAT_ERR]));
		send_addr(32'd0, st);
		check_value("error flag clear", 32'd0, 32'(st[`STAT_ERR]));

		// Overrun: WDATA sent while a slow read is still on the bus
		pat = $random(seed);
		base = int'(pat[5:0]) % 63;
		send_addr(32'(base) << 2, st);
		@(posedge clk);
		slow <= 1'b1;
		shift_ir(IR_RDATA);
		send_empty_dr();
		// Busy seen just before the WDATA decides whether it is dropped
		shift_ir(IR_STATUS);
		shift_dr(32'd0, st);
		exp_ovr = st[`STAT_BUSY];
		shift_ir(IR_WDATA);
		send_empty_dr();
		// An accepted empty WDATA writes zero to the word after the read
		if (!exp_ovr) begin
			ref_mem[base + 1] = 32'd0;
		end
		poll_idle(st);
		slow <= 1'b0;
		check_value("overrun flag set", 32'(exp_ovr), 32'(st[`STAT_OVR]));
		check_value("busy after overrun", 32'd0, 32'(st[`STAT_BUSY]));
		send_addr(32'd0, st);
		check_value("overrun flag clear", 32'd0, 32'(st[`STAT_OVR]));

		compare_memory("final memory");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/jtag2ahb_props.sv ====
// ****************************************
// Concurrent checks on the AHB and JTAG
// ports, bound into the bridge top level
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module jtag2ahb_props (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire                         tck,
	input  wire  [1:0]                  htrans,
	input  wire  [31:0]                 haddr,
	input  wire                         hready,
	input  wire  [2:0]                  hburst,
	input  wire  [2:0]                  hsize,
	input  wire  [3:0]                  hprot,
	input  wire                         hmastlock,
	input  wire                         tdo_en,
	input  jtag2ahb_pkg::tap_state_t    tap_state
);

	import jtag2ahb_pkg::*;

	// Address phase held through wait states
	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans == `AHB_TRANS_NONSEQ && !hready)
		|=> (htrans == `AHB_TRANS_NONSEQ && $stable(haddr)))
		else $error("AHB address phase changed while hready was low");

	single_word: assert property (@(posedge clk) disable iff (!rst_n)
		hburst == `AHB_BURST_SINGLE && hsize == `AHB_SIZE_WORD)
		else $error("AHB transfer is not a single word transfer");

	// Plain data access, never locked
	data_access: assert property (@(posedge clk) disable iff (!rst_n)
		(htrans == `AHB_TRANS_NONSEQ) |-> (hprot == `AHB_PROT_DATA && !hmastlock))
		else $error("AHB transfer is locked or not a data access");

	// tdo_en follows the state seen at the last falling edge
	tdo_quiet: assert property (@(posedge tck) disable iff (!rst_n)
		!(tap_state == TAP_SHIFT_DR || tap_state == TAP_SHIFT_IR) |-> !tdo_en)
		else $error("tdo_en high outside the Shift states");

endmodule

bind jtag2ahb_bridge jtag2ahb_props u_props (
	.clk(clk),
	.rst_n(rst_n),
	.tck(tck),
	.htrans(htrans),
	.haddr(haddr),
	.hready(hready),
	.hburst(hburst),
	.hsize(hsize),
	.hprot(hprot),
	.hmastlock(hmastlock),
	.tdo_en(tdo_en),
	.tap_state(u_tap.state)
);

`default_nettype wire

// ==== testbench/tb_ahb_mem.sv ====
// ****************************************
// AHB-Lite slave memory model, 64 words
// Random wait states, slow mode, error
// response at or above address 0x100
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module tb_ahb_mem #(
	parameter int SLOW_WAITS = 64
) (
	input  wire         clk,
	input  wire         rst_n,
	input  wire         slow,
	input  wire  [1:0]  htrans,
	input  wire  [31:0] haddr,
	input  wire         hwrite,
	input  wire  [31:0] hwdata,
	output logic [31:0] hrdata,
	output logic        hready,
	output logic        hresp
);

	logic [31:0] mem [0:63];
	logic        active;
	logic        wr_q;
	logic        err_q;
	logic [5:0]  idx_q;
	logic [7:0]  wait_left;
	logic [7:0]  waits;
	logic [31:0] rnd;
	int          seed = 9;

	// Fill value built from the byte address
	initial begin
		for (int i = 0; i < 64; i++) begin
			mem[i] = 32'h5A5A_0000 ^ ((32'(i) << 2) * 32'h0001_0001);
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			active <= 1'b0;
			hready <= 1'b1;
			hresp <= 1'b0;
			wait_left <= 8'd0;
		end else begin
			if (active && hready) begin
				if (wr_q && !err_q) begin
					mem[idx_q] <= hwdata;
				end
				active <= 1'b0;
				hresp <= 1'b0;
			end else if (active) begin
				if (wait_left <= 8'd1) begin
					hready <= 1'b1;
				end
				wait_left <= wait_left - 8'd1;
			end
			// Address phase accepted
			if (hready && htrans == `AHB_TRANS_NONSEQ) begin
				rnd = $random(seed);
				waits = slow ? 8'(SLOW_WAITS) : {6'd0, rnd[1:0]};
				// Two-cycle error response needs one low cycle
				if (haddr >= 32'h100 && waits == 8'd0) begin
					waits = 8'd1;
				end
				active <= 1'b1;
				idx_q <= haddr[7:2];
				wr_q <= hwrite;
				err_q <= (haddr >= 32'h100);
				hresp <= (haddr >= 32'h100);
				hready <= (waits == 8'd0);
				wait_left <= waits;
				hrdata <= mem[haddr[7:2]];
			end
		end
	end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// ****************************************
// Free-running clock for the testbench
// ****************************************
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD = 8
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== design/jtag2ahb_bridge.sv ====
// ****************************************
// JTAG to AHB-Lite debug bridge top level
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module jtag2ahb_bridge (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        tck,
	input  wire                        tms,
	input  wire                        tdi,
	output logic                       tdo,
	output logic                       tdo_en,
	output logic [`AHB_ADDR_W-1:0]     haddr,
	output logic [2:0]                 hburst,
	output logic                       hmastlock,
	output logic [3:0]                 hprot,
	output logic [2:0]                 hsize,
	output logic [1:0]                 htrans,
	output logic [`AHB_DATA_W-1:0]     hwdata,
	output logic                       hwrite,
	input  wire  [`AHB_DATA_W-1:0]     hrdata,
	input  wire                        hready,
	input  wire                        hresp
);

	import jtag2ahb_pkg::*;

	logic                    cmd_send;
	cmd_kind_t               cmd_kind;
	logic [`JTAG_DR_W-1:0]   cmd_word;
	logic                    busy_tck;
	logic                    cmd_strobe;
	cmd_kind_t               cmd_kind_clk;
	logic [`JTAG_DR_W-1:0]   cmd_word_clk;
	logic                    done_clk;
	logic [`JTAG_DR_W-1:0]   read_data;
	logic                    err_flag;
	logic                    ovr_flag;
	logic                    req_valid;
	logic                    req_write;
	logic [`AHB_ADDR_W-1:0]  req_addr;
	logic [`AHB_DATA_W-1:0]  req_wdata;
	logic                    req_ready;
	logic                    rsp_valid;
	logic [`AHB_DATA_W-1:0]  rsp_rdata;
	logic                    rsp_err;

	// Read data and flags reach the TAP as quasi-static values
	jtag_tap u_tap (
		.tck(tck),
		.rst_n(rst_n),
		.tms(tms),
		.tdi(tdi),
		.tdo(tdo),
		.tdo_en(tdo_en),
		.cmd_send(cmd_send),
		.cmd_kind(cmd_kind),
		.cmd_word(cmd_word),
		.busy_tck(busy_tck),
		.err_tck(err_flag),
		.ovr_tck(ovr_flag),
		.read_data_tck(read_data)
	);

	jtag_cdc_channel u_channel (
		.tck(tck),
		.clk(clk),
		.rst_n(rst_n),
		.cmd_send(cmd_send),
		.cmd_kind(cmd_kind),
		.cmd_word(cmd_word),
		.cmd_strobe(cmd_strobe),
		.cmd_kind_clk(cmd_kind_clk),
		.cmd_word_clk(cmd_word_clk),
		.done_clk(done_clk),
		.busy_tck(busy_tck)
	);

	jtag_cmd_unit u_cmd_unit (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_strobe(cmd_strobe),
		.cmd_kind_clk(cmd_kind_clk),
		.cmd_word_clk(cmd_word_clk),
		.done_clk(done_clk),
		.read_data(read_data),
		.err_flag(err_flag),
		.ovr_flag(ovr_flag),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err)
	);

	ahb_single_master u_master (
		.clk(clk),
		.rst_n(rst_n),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.rsp_valid(rsp_valid),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.haddr(haddr),
		.hburst(hburst),
		.hmastlock(hmastlock),
		.hprot(hprot),
		.hsize(hsize),
		.htrans(htrans),
		.hwdata(hwdata),
		.hwrite(hwrite),
		.hrdata(hrdata),
		.hready(hready),
		.hresp(hresp)
	);

endmodule

`default_nettype wire

// ==== design/ahb_single_master.sv ====
// ****************************************
// AHB-Lite master, one 32-bit single
// transfer per accepted request
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module ahb_single_master (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        req_valid,
	input  wire                        req_write,
	input  wire  [`AHB_ADDR_W-1:0]     req_addr,
	input  wire  [`AHB_DATA_W-1:0]     req_wdata,
	output logic                       req_ready,
	output logic                       rsp_valid,
	output logic [`AHB_DATA_W-1:0]     rsp_rdata,
	output logic                       rsp_err,
	output logic [`AHB_ADDR_W-1:0]     haddr,
	output logic [2:0]                 hburst,
	output logic                       hmastlock,
	output logic [3:0]                 hprot,
	output logic [2:0]                 hsize,
	output logic [1:0]                 htrans,
	output logic [`AHB_DATA_W-1:0]     hwdata,
	output logic                       hwrite,
	input  wire  [`AHB_DATA_W-1:0]     hrdata,
	input  wire                        hready,
	input  wire                        hresp
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_ADDR,
		M_DATA
	} mst_state_t;

	mst_state_t              state;
	logic [`AHB_ADDR_W-1:0]  addr_q;
	logic [`AHB_DATA_W-1:0]  wdata_q;
	logic                    write_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= M_IDLE;
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				M_IDLE: begin
					if (req_valid) begin
						state <= M_ADDR;
					end
				end
				M_ADDR: begin
					if (hready) begin
						state <= M_DATA;
					end
				end
				M_DATA: begin
					if (hready) begin
						state <= M_IDLE;
						rsp_valid <= 1'b1;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge clk) begin
		if (state == M_IDLE && req_valid) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			write_q <= req_write;
		end
		if (state == M_DATA && hready) begin
			rsp_rdata <= hrdata;
			rsp_err <= hresp;
		end
	end

	assign req_ready = (state == M_IDLE);

	assign htrans = (state == M_ADDR) ? `AHB_TRANS_NONSEQ : `AHB_TRANS_IDLE;
	assign haddr = addr_q;
	assign hwrite = write_q;
	assign hwdata = wdata_q;
	assign hburst = `AHB_BURST_SINGLE;
	assign hsize = `AHB_SIZE_WORD;
	assign hprot = `AHB_PROT_DATA;
	assign hmastlock = 1'b0;

endmodule

`default_nettype wire

// ==== design/jtag_cmd_unit.sv ====
// ****************************************
// Command decoder on clk: address register
// with auto-increment, read data, flags
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module jtag_cmd_unit (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        cmd_strobe,
	input  jtag2ahb_pkg::cmd_kind_t    cmd_kind_clk,
	input  wire  [`JTAG_DR_W-1:0]      cmd_word_clk,
	output logic                       done_clk,
	output logic [`JTAG_DR_W-1:0]      read_data,
	output logic                       err_flag,
	output logic                       ovr_flag,
	output logic                       req_valid,
	output logic                       req_write,
	output logic [`AHB_ADDR_W-1:0]     req_addr,
	output logic [`AHB_DATA_W-1:0]     req_wdata,
	input  wire                        req_ready,
	input  wire                        rsp_valid,
	input  wire  [`AHB_DATA_W-1:0]     rsp_rdata,
	input  wire                        rsp_err
);

	import jtag2ahb_pkg::*;

	logic busy;
	logic addr_fin;
	logic finish;
	logic accept;
	logic drop;

	// A finishing command frees the unit in the same cycle
	assign finish = rsp_valid | addr_fin;
	assign accept = cmd_strobe & (~busy | finish);
	assign drop = cmd_strobe & busy & ~finish;

	// One done pulse per command, dropped ones included
	assign done_clk = finish | drop;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			addr_fin <= 1'b0;
			req_valid <= 1'b0;
			req_write <= 1'b0;
			req_addr <= '0;
			read_data <= '0;
			err_flag <= 1'b0;
			ovr_flag <= 1'b0;
		end else begin
			addr_fin <= 1'b0;
			if (req_valid && req_ready) begin
				req_valid <= 1'b0;
			end
			if (rsp_valid) begin
				req_addr <= req_addr + `AHB_ADDR_W'(4);
				if (rsp_err) begin
					err_flag <= 1'b1;
				end
				if (!req_write) begin
					read_data <= rsp_rdata;
				end
			end
			if (finish) begin
				busy <= 1'b0;
			end
			if (drop) begin
				ovr_flag <= 1'b1;
			end
			// Later assignments win over the completion above
			if (accept) begin
				busy <= 1'b1;
				case (cmd_kind_clk)
					CMD_WRITE: begin
						req_write <= 1'b1;
						req_valid <= 1'b1;
					end
					CMD_READ: begin
						req_write <= 1'b0;
						req_valid <= 1'b1;
					end
					default: begin
						req_addr <= cmd_word_clk;
						err_flag <= 1'b0;
						ovr_flag <= 1'b0;
						addr_fin <= 1'b1;
					end
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && cmd_kind_clk == CMD_WRITE) begin
			req_wdata <= cmd_word_clk;
		end
	end

endmodule

`default_nettype wire

// ==== design/jtag_cdc_channel.sv ====
// ****************************************
// Toggle handshake between tck and clk
// Command word forward, done toggle back
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module jtag_cdc_channel (
	input  wire                        tck,
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        cmd_send,
	input  jtag2ahb_pkg::cmd_kind_t    cmd_kind,
	input  wire  [`JTAG_DR_W-1:0]      cmd_word,
	output logic                       cmd_strobe,
	output jtag2ahb_pkg::cmd_kind_t    cmd_kind_clk,
	output logic [`JTAG_DR_W-1:0]      cmd_word_clk,
	input  wire                        done_clk,
	output logic                       busy_tck
);

	import jtag2ahb_pkg::*;

	logic                   send_tgl;
	logic [`JTAG_DR_W-1:0]  word_hold;
	cmd_kind_t              kind_hold;
	logic [1:0]             done_sync;
	logic [2:0]             send_sync;
	logic                   done_tgl;

	// tck side, word held until the next send
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			send_tgl <= 1'b0;
			done_sync <= 2'b00;
		end else begin
			done_sync <= {done_sync[0], done_tgl};
			if (cmd_send) begin
				send_tgl <= ~send_tgl;
			end
		end
	end

	always_ff @(posedge tck) begin
		if (cmd_send) begin
			word_hold <= cmd_word;
			kind_hold <= cmd_kind;
		end
	end

	assign busy_tck = send_tgl ^ done_sync[1];

	// clk side, two sync stages plus one for edge detection
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			send_sync <= 3'b000;
			cmd_strobe <= 1'b0;
			done_tgl <= 1'b0;
		end else begin
			send_sync <= {send_sync[1:0], send_tgl};
			cmd_strobe <= send_sync[2] ^ send_sync[1];
			if (done_clk) begin
				done_tgl <= ~done_tgl;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (send_sync[2] ^ send_sync[1]) begin
			cmd_word_clk <= word_hold;
			cmd_kind_clk <= kind_hold;
		end
	end

endmodule

`default_nettype wire

// ==== design/jtag_tap.sv ====
// ****************************************
// JTAG TAP controller on tck
// 8-bit IR, shared 32-bit DR, bypass bit,
// command emission in Update-DR
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

module jtag_tap (
	input  wire                        tck,
	input  wire                        rst_n,
	input  wire                        tms,
	input  wire                        tdi,
	output logic                       tdo,
	output logic                       tdo_en,
	output logic                       cmd_send,
	output jtag2ahb_pkg::cmd_kind_t    cmd_kind,
	output logic [`JTAG_DR_W-1:0]      cmd_word,
	input  wire                        busy_tck,
	input  wire                        err_tck,
	input  wire                        ovr_tck,
	input  wire  [`JTAG_DR_W-1:0]      read_data_tck
);

	import jtag2ahb_pkg::*;

	tap_state_t             state;
	tap_state_t             state_nxt;
	logic [`JTAG_IR_W-1:0]  ir;
	logic [`JTAG_IR_W-1:0]  ir_sr;
	logic [`JTAG_DR_W-1:0]  dr;
	logic                   bypass;
	logic                   sel_bypass;
	logic                   is_cmd;
	logic [`JTAG_DR_W-1:0]  rdata_q;
	logic                   err_q;
	logic                   ovr_q;
	logic [`JTAG_DR_W-1:0]  status_word;

	// ****************************************
	// TAP state machine
	// ****************************************
	always_comb begin
		case (state)
			TAP_RESET:      state_nxt = tms ? TAP_RESET : TAP_IDLE;
			TAP_IDLE:       state_nxt = tms ? TAP_SEL_DR : TAP_IDLE;
			TAP_SEL_DR:     state_nxt = tms ? TAP_SEL_IR : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_nxt = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_nxt = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_nxt = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_nxt = tms ? TAP_SEL_DR : TAP_IDLE;
			TAP_SEL_IR:     state_nxt = tms ? TAP_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_nxt = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_nxt = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_nxt = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			TAP_UPDATE_IR:  state_nxt = tms ? TAP_SEL_DR : TAP_IDLE;
			default:        state_nxt = TAP_RESET;
		endcase
	end

	always_ff @(posedge tck) begin
		if (!rst_n) begin
			state <= TAP_RESET;
		end else begin
			state <= state_nxt;
		end
	end

	// Instruction register, IDCODE after reset
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			ir <= IR_IDCODE;
		end else if (state == TAP_RESET) begin
			ir <= IR_IDCODE;
		end else if (state == TAP_UPDATE_IR) begin
			ir <= ir_sr;
		end
	end

	always_ff @(posedge tck) begin
		if (state == TAP_CAPTURE_IR) begin
			ir_sr <= `JTAG_IR_W'(1);
		end else if (state == TAP_SHIFT_IR) begin
			ir_sr <= {tdi, ir_sr[`JTAG_IR_W-1:1]};
		end
	end

	// Instruction decode, unknown codes fall to bypass
	always_comb begin
		sel_bypass = 1'b0;
		is_cmd = 1'b1;
		cmd_kind = CMD_ADDR;
		case (ir)
			IR_ADDR:  cmd_kind = CMD_ADDR;
			IR_WDATA: cmd_kind = CMD_WRITE;
			IR_RDATA: cmd_kind = CMD_READ;
			IR_IDCODE, IR_STATUS: is_cmd = 1'b0;
			default: begin
				is_cmd = 1'b0;
				sel_bypass = 1'b1;
			end
		endcase
	end

	// ****************************************
	// Data registers
	// ****************************************

	// Bus-side values only move while no command is in flight
	always_ff @(posedge tck) begin
		if (!rst_n) begin
			err_q <= 1'b0;
			ovr_q <= 1'b0;
			rdata_q <= '0;
		end else if (!busy_tck) begin
			err_q <= err_tck;
			ovr_q <= ovr_tck;
			rdata_q <= read_data_tck;
		end
	end

	always_comb begin
		status_word = '0;
		status_word[`STAT_BUSY] = busy_tck;
		status_word[`STAT_ERR] = err_q;
		status_word[`STAT_OVR] = ovr_q;
	end

	always_ff @(posedge tck) begin
		if (state == TAP_CAPTURE_DR) begin
			bypass <= 1'b0;
			case (ir)
				IR_IDCODE: dr <= `JTAG_IDCODE;
				IR_RDATA:  dr <= rdata_q;
				IR_STATUS: dr <= status_word;
				default:   dr <= '0;
			endcase
		end else if (state == TAP_SHIFT_DR) begin
			bypass <= tdi;
			dr <= {tdi, dr[`JTAG_DR_W-1:1]};
		end
	end

	assign cmd_send = (state == TAP_UPDATE_DR) && is_cmd;
	assign cmd_word = dr;

	// TDO launches on the falling edge
	always_ff @(negedge tck) begin
		if (!rst_n) begin
			tdo <= 1'b0;
			tdo_en <= 1'b0;
		end else begin
			tdo_en <= (state == TAP_SHIFT_IR) || (state == TAP_SHIFT_DR);
			if (state == TAP_SHIFT_IR) begin
				tdo <= ir_sr[0];
			end else if (sel_bypass) begin
				tdo <= bypass;
			end else begin
				tdo <= dr[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/jtag2ahb_pkg.sv ====
// ****************************************
// Types shared by the bridge: instruction
// codes, TAP states and command kinds
// ****************************************
`default_nettype none

`include "jtag2ahb_consts.svh"

package jtag2ahb_pkg;

	typedef enum logic [`JTAG_IR_W-1:0] {
		IR_IDCODE = 8'h01,
		IR_ADDR   = 8'h10,
		IR_WDATA  = 8'h11,
		IR_RDATA  = 8'h12,
		IR_STATUS = 8'h13,
		IR_BYPASS = 8'hFF
	} jtag_instr_t;

	// Usual IEEE 1149.1 state encoding
	typedef enum logic [3:0] {
		TAP_EXIT2_DR  = 4'h0, TAP_EXIT1_DR  = 4'h1, TAP_SHIFT_DR  = 4'h2, TAP_PAUSE_DR = 4'h3,
		TAP_SEL_IR    = 4'h4, TAP_UPDATE_DR = 4'h5, TAP_CAPTURE_DR = 4'h6, TAP_SEL_DR  = 4'h7,
		TAP_EXIT2_IR  = 4'h8, TAP_EXIT1_IR  = 4'h9, TAP_SHIFT_IR  = 4'hA, TAP_PAUSE_IR = 4'hB,
		TAP_IDLE      = 4'hC, TAP_UPDATE_IR = 4'hD, TAP_CAPTURE_IR = 4'hE, TAP_RESET   = 4'hF
	} tap_state_t;

	typedef enum logic [1:0] {
		CMD_ADDR  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_READ  = 2'd2
	} cmd_kind_t;

endpackage

`default_nettype wire

// ==== design/jtag2ahb_consts.svh ====
// ****************************************
// Widths, identifier, status bit positions
// and AHB-Lite control codes of the bridge
// ****************************************
`ifndef JTAG2AHB_CONSTS_SVH
`define JTAG2AHB_CONSTS_SVH

`define JTAG_IR_W 8
`define JTAG_DR_W 32
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

`define JTAG_IDCODE 32'h1A2B_3C4D

// Status word bits
`define STAT_BUSY 0
`define STAT_ERR 1
`define STAT_OVR 2

// AHB-Lite encodings used by the master
`define AHB_TRANS_IDLE 2'b00
`define AHB_TRANS_NONSEQ 2'b10
`define AHB_BURST_SINGLE 3'b000
`define AHB_SIZE_WORD 3'b010
`define AHB_PROT_DATA 4'b0001

`endif
